//--- rtl/cache_pkg.sv
package cache_pkg;

    // geometry
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS       = 4;
    localparam int NUM_WAYS       = 2;

    // split of a word address
    localparam int PROC_ADDR_W = 30;
    localparam int OFFSET_W    = $clog2(WORDS_PER_LINE);
    localparam int INDEX_W     = $clog2(NUM_SETS);
    localparam int TAG_W       = PROC_ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [WORD_W-1:0]                word_t;
    typedef logic [WORD_W*WORDS_PER_LINE-1:0] line_t;
    typedef logic [PROC_ADDR_W-1:0]           proc_addr_t;
    typedef logic [TAG_W+INDEX_W-1:0]         line_addr_t;
    typedef logic [TAG_W-1:0]                 tag_t;
    typedef logic [INDEX_W-1:0]               index_t;
    typedef logic [OFFSET_W-1:0]              offset_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]      way_t;

    // flat {index, way} position in the valid and dirty vectors
    typedef logic [$clog2(NUM_SETS*NUM_WAYS)-1:0] slot_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        ALLOCATE
    } ctrl_state_t;

endpackage

//--- rtl/way_array.sv
module way_array #(
    parameter type entry_t = logic
) (
    input  logic               clk,
    input  logic               we,
    input  cache_pkg::index_t  index,
    input  cache_pkg::way_t    way,
    input  entry_t             wdata,
    output entry_t             set_entries [cache_pkg::NUM_WAYS]
);
    import cache_pkg::*;

    entry_t store [NUM_SETS][NUM_WAYS];

    always_ff @(posedge clk) begin
        if (we) begin
            store[index][way] <= wdata;
        end
    end

    // both ways of the addressed set are read without a clock
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            set_entries[w] = store[index][w];
        end
    end

endmodule

//--- rtl/word_access.sv
module word_access (
    input  cache_pkg::line_t   line_in,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::word_t   wdata,
    input  logic               merge_en,
    output cache_pkg::word_t   rdata,
    output cache_pkg::line_t   line_merged
);
    import cache_pkg::*;

    // word 0 sits in the low bits of the line
    assign rdata = line_in[offset*WORD_W +: WORD_W];

    always_comb begin
        line_merged = line_in;
        // only a write replaces the addressed word
        if (merge_en) begin
            line_merged[offset*WORD_W +: WORD_W] = wdata;
        end
    end

endmodule

//--- rtl/set_lookup.sv
module set_lookup (
    input  cache_pkg::proc_addr_t         proc_addr,
    input  cache_pkg::tag_t               stored_tags [cache_pkg::NUM_WAYS],
    input  logic [cache_pkg::NUM_WAYS-1:0] valid_bits,
    input  cache_pkg::way_t               lru_bit,
    output cache_pkg::tag_t               tag,
    output cache_pkg::index_t             index,
    output cache_pkg::offset_t            offset,
    output logic                          hit,
    output cache_pkg::way_t               hit_way,
    output cache_pkg::way_t               victim_way,
    output cache_pkg::slot_t              victim_dirty_sel,
    output cache_pkg::tag_t               victim_tag
);
    import cache_pkg::*;

    logic [NUM_WAYS-1:0] way_match;

    assign {tag, index, offset} = proc_addr;

    // a way only matches when it holds a valid line
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = valid_bits[w] && (stored_tags[w] == tag);
        end
    end

    assign hit     = |way_match;
    assign hit_way = way_t'(way_match[1]);

    // empty ways fill first, then the least recently used one
    always_comb begin
        if (!valid_bits[0]) begin
            victim_way = way_t'(0);
        end else if (!valid_bits[1]) begin
            victim_way = way_t'(1);
        end else begin
            victim_way = lru_bit;
        end
    end

    assign victim_dirty_sel = {index, victim_way};
    assign victim_tag       = stored_tags[victim_way];

endmodule

//--- rtl/miss_control.sv
module miss_control (
    input  logic                           clk,
    input  logic                           proc_reset,
    input  logic                           proc_read,
    input  logic                           proc_write,
    input  cache_pkg::index_t              index,
    input  cache_pkg::tag_t                tag,
    input  logic                           hit,
    input  cache_pkg::way_t                hit_way,
    input  cache_pkg::way_t                victim_way,
    input  cache_pkg::slot_t               victim_dirty_sel,
    input  cache_pkg::tag_t                victim_tag,
    input  logic                           mem_ready,
    input  cache_pkg::line_t               mem_rdata,
    output logic [cache_pkg::NUM_WAYS-1:0] valid_bits,
    output cache_pkg::way_t                lru_bit,
    output logic                           proc_stall,
    output logic                           mem_read,
    output logic                           mem_write,
    output cache_pkg::line_addr_t          mem_addr,
    output logic                           line_we,
    output logic                           tag_we,
    output cache_pkg::way_t                access_way,
    output logic                           fill_sel,
    output cache_pkg::line_t               mem_line_r
);
    import cache_pkg::*;

    ctrl_state_t                   state_q;
    ctrl_state_t                   state_d;
    logic [NUM_SETS*NUM_WAYS-1:0]  valid_q;
    logic [NUM_SETS*NUM_WAYS-1:0]  dirty_q;
    logic [NUM_SETS-1:0]           lru_q;
    logic                          mem_ready_r;
    logic                          req;
    logic                          hit_access;
    logic                          fill_done;
    logic                          victim_dirty;
    slot_t                         hit_slot;

    assign req          = proc_read | proc_write;
    assign hit_access   = (state_q == IDLE) && req && hit;
    assign fill_done    = (state_q == ALLOCATE) && mem_ready_r;
    assign hit_slot     = {index, hit_way};
    assign victim_dirty = dirty_q[victim_dirty_sel];

    // per-set view for the lookup
    assign valid_bits = valid_q[index*NUM_WAYS +: NUM_WAYS];
    assign lru_bit    = way_t'(lru_q[index]);

    always_comb begin
        state_d    = state_q;
        proc_stall = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = {tag, index};
        line_we    = 1'b0;
        tag_we     = 1'b0;
        access_way = hit_way;
        fill_sel   = 1'b0;
        case (state_q)
            IDLE: begin
                if (req && !hit) begin
                    proc_stall = 1'b1;
                    if (victim_dirty) begin
                        mem_write = 1'b1;
                        mem_addr  = {victim_tag, index};
                        state_d   = WRITE_BACK;
                    end else begin
                        mem_read = 1'b1;
                        state_d  = ALLOCATE;
                    end
                end else if (proc_write && hit) begin
                    line_we = 1'b1;
                end
            end
            WRITE_BACK: begin
                proc_stall = 1'b1;
                mem_write  = 1'b1;
                mem_addr   = {victim_tag, index};
                access_way = victim_way;
                if (mem_ready) begin
                    state_d = ALLOCATE;
                end
            end
            ALLOCATE: begin
                access_way = victim_way;
                fill_sel   = 1'b1;
                // the registered ready marks the fill cycle
                if (mem_ready_r) begin
                    line_we = 1'b1;
                    tag_we  = 1'b1;
                    state_d = IDLE;
                end else begin
                    proc_stall = 1'b1;
                    mem_read   = 1'b1;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q     <= IDLE;
            valid_q     <= '0;
            dirty_q     <= '0;
            lru_q       <= '0;
            mem_ready_r <= 1'b0;
        end else begin
            state_q <= state_d;
            // a write-back ready must not look like read data
            mem_ready_r <= mem_ready && (state_q == ALLOCATE);
            if (hit_access) begin
                lru_q[index] <= ~hit_way;
                if (proc_write) begin
                    dirty_q[hit_slot] <= 1'b1;
                end
            end
            if (fill_done) begin
                valid_q[victim_dirty_sel] <= 1'b1;
                dirty_q[victim_dirty_sel] <= proc_write;
                lru_q[index]              <= ~victim_way;
            end
        end
    end

    // response line held for the fill cycle
    always_ff @(posedge clk) begin
        mem_line_r <= mem_rdata;
    end

endmodule

//--- rtl/cache_top.sv
module cache_top (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::proc_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    input  cache_pkg::line_t      mem_rdata,
    input  logic                  mem_ready,
    output logic                  proc_stall,
    output cache_pkg::word_t      proc_rdata,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata
);
    import cache_pkg::*;

    tag_t                tag;
    index_t              index;
    offset_t             offset;
    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    slot_t               victim_dirty_sel;
    tag_t                victim_tag;
    logic [NUM_WAYS-1:0] valid_bits;
    way_t                lru_bit;
    logic                line_we;
    logic                tag_we;
    way_t                access_way;
    logic                fill_sel;
    line_t               mem_line_r;
    line_t               set_lines [NUM_WAYS];
    tag_t                set_tags [NUM_WAYS];
    line_t               line_src;
    line_t               line_merged;

    // stored line on a hit, fetched line on a fill
    assign line_src  = fill_sel ? mem_line_r : set_lines[access_way];
    assign mem_wdata = set_lines[victim_way];

    set_lookup set_lookup_i (
        .proc_addr        (proc_addr),
        .stored_tags      (set_tags),
        .valid_bits       (valid_bits),
        .lru_bit          (lru_bit),
        .tag              (tag),
        .index            (index),
        .offset           (offset),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .victim_dirty_sel (victim_dirty_sel),
        .victim_tag       (victim_tag)
    );

    miss_control miss_control_i (
        .clk              (clk),
        .proc_reset       (proc_reset),
        .proc_read        (proc_read),
        .proc_write       (proc_write),
        .index            (index),
        .tag              (tag),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .victim_dirty_sel (victim_dirty_sel),
        .victim_tag       (victim_tag),
        .mem_ready        (mem_ready),
        .mem_rdata        (mem_rdata),
        .valid_bits       (valid_bits),
        .lru_bit          (lru_bit),
        .proc_stall       (proc_stall),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_addr         (mem_addr),
        .line_we          (line_we),
        .tag_we           (tag_we),
        .access_way       (access_way),
        .fill_sel         (fill_sel),
        .mem_line_r       (mem_line_r)
    );

    word_access word_access_i (
        .line_in     (line_src),
        .offset      (offset),
        .wdata       (proc_wdata),
        .merge_en    (proc_write),
        .rdata       (proc_rdata),
        .line_merged (line_merged)
    );

    way_array #(
        .entry_t (line_t)
    ) line_array_i (
        .clk         (clk),
        .we          (line_we),
        .index       (index),
        .way         (access_way),
        .wdata       (line_merged),
        .set_entries (set_lines)
    );

    way_array #(
        .entry_t (tag_t)
    ) tag_array_i (
        .clk         (clk),
        .we          (tag_we),
        .index       (index),
        .way         (access_way),
        .wdata       (tag),
        .set_entries (set_tags)
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half low
    always begin
        #(PERIOD / 2) clk = ~clk;
    end

endmodule

//--- tests/mem_model.sv
module mem_model (
    input  logic                  clk,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  cache_pkg::line_addr_t mem_addr,
    input  cache_pkg::line_t      mem_wdata,
    output bit                    mem_ready,
    output cache_pkg::line_t      mem_rdata,
    output int                    read_count,
    output int                    write_count
);
    import cache_pkg::*;

    localparam int NUM_LINES = 256;

    line_t      lines [NUM_LINES];
    bit         busy;
    int         wait_cnt;
    bit         req_write;
    line_addr_t req_addr;
    line_t      req_wdata;
    bit [WORD_W*WORDS_PER_LINE-1:0] rdata_q;

    assign mem_rdata = rdata_q;

    // every word starts as a mix of its full word address
    initial begin
        int i;
        int w;
        for (i = 0; i < NUM_LINES; i++) begin
            for (w = 0; w < WORDS_PER_LINE; w++) begin
                lines[i][w*WORD_W +: WORD_W] =
                    ((i * WORDS_PER_LINE + w) * 32'h9e37_79b1) ^ 32'h5ac3_1f07;
            end
        end
    end

    always @(posedge clk) begin
        mem_ready <= 1'b0;
        if (busy) begin
            if (wait_cnt == 0) begin
                busy      <= 1'b0;
                mem_ready <= 1'b1;
                if (req_write) begin
                    lines[req_addr[7:0]] <= req_wdata;
                    write_count          <= write_count + 1;
                end else begin
                    rdata_q    <= lines[req_addr[7:0]];
                    read_count <= read_count + 1;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if ((mem_read || mem_write) && !mem_ready) begin
            // answer 1 to 8 cycles after the request is taken
            busy      <= 1'b1;
            wait_cnt  <= $urandom_range(1, 8) - 1;
            req_write <= mem_write;
            req_addr  <= mem_addr;
            req_wdata <= mem_wdata;
        end
    end

endmodule

//--- tests/cache_tb.sv
module cache_tb;
    import cache_pkg::*;

    localparam int CLK_PERIOD        = 10;
    localparam int RESET_CYCLES      = 10;
    localparam int STRESS_ACCESSES   = 60;
    // directed accesses plus the stress loop
    localparam int NUM_ACCESSES      = 19 + STRESS_ACCESSES;
    localparam int CYCLES_PER_ACCESS = 20;
    localparam int WATCHDOG_TIME     =
        (NUM_ACCESSES * CYCLES_PER_ACCESS + RESET_CYCLES) * CLK_PERIOD;
    localparam int SHADOW_WORDS      = 1024;

    logic       clk;
    logic       proc_reset;
    logic       proc_read;
    logic       proc_write;
    proc_addr_t proc_addr;
    word_t      proc_wdata;
    logic       proc_stall;
    word_t      proc_rdata;
    logic       mem_read;
    logic       mem_write;
    line_addr_t mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata;
    bit         mem_ready;
    int         read_count;
    int         write_count;

    word_t shadow [SHADOW_WORDS];
    int    error_count;
    int    check_count;
    int    test_count;
    int    last_stall;
    int    errors_mark;
    int    reads_mark;
    int    writes_mark;
    int    seed_draw;

    tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_i (.clk(clk));

    cache_top cache_top_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    mem_model mem_model_i (
        .clk         (clk),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .read_count  (read_count),
        .write_count (write_count)
    );

    function automatic word_t pattern_word(input int word_addr);
        return (word_t'(word_addr) * 32'h9e37_79b1) ^ 32'h5ac3_1f07;
    endfunction

    function automatic proc_addr_t make_addr(input int tag, input int idx, input int off);
        return {tag_t'(tag), index_t'(idx), offset_t'(off)};
    endfunction

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic start_test();
        errors_mark = error_count;
        reads_mark  = read_count;
        writes_mark = write_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %s finished with %0d errors", name, error_count - errors_mark);
    endtask

    // one request held until the stall drops
    task automatic access(input bit is_write, input proc_addr_t addr, input word_t wdata,
                          output word_t rdata);
        @(negedge clk);
        proc_read  = !is_write;
        proc_write = is_write;
        proc_addr  = addr;
        proc_wdata = wdata;
        last_stall = 0;
        // outputs settle well before the rising edge
        #1;
        while (proc_stall) begin
            @(negedge clk);
            #1;
            last_stall++;
        end
        rdata = proc_rdata;
        @(negedge clk);
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    task automatic read_word(input proc_addr_t addr);
        word_t rdata;
        access(1'b0, addr, '0, rdata);
        check_value($sformatf("read of %h", addr), rdata, shadow[addr[9:0]]);
    endtask

    task automatic write_word(input proc_addr_t addr, input word_t data);
        word_t ignored;
        access(1'b1, addr, data, ignored);
        shadow[addr[9:0]] = data;
    endtask

    task automatic apply_reset();
        proc_reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        proc_reset = 1'b0;
        #1;
        check_value("stall and memory requests after reset",
                    word_t'({proc_stall, mem_read, mem_write}), 0);
    endtask

    task automatic read_miss_then_hit();
        start_test();
        read_word(make_addr(1, 0, 0));
        check_value("miss stall", (last_stall > 0) ? 1 : 0, 1);
        check_value("miss memory reads", read_count - reads_mark, 1);
        read_word(make_addr(1, 0, 2));
        check_value("hit stall", last_stall, 0);
        check_value("hit memory reads", read_count - reads_mark, 1);
        check_value("memory writes", write_count - writes_mark, 0);
        finish_test("read miss then hit");
    endtask

    task automatic write_hit_update();
        int off;
        start_test();
        write_word(make_addr(1, 0, 1), 32'hcafe_0001);
        check_value("write hit stall", last_stall, 0);
        for (off = 0; off < WORDS_PER_LINE; off++) begin
            read_word(make_addr(1, 0, off));
            check_value("read hit stall", last_stall, 0);
        end
        check_value("memory reads", read_count - reads_mark, 0);
        check_value("memory writes", write_count - writes_mark, 0);
        finish_test("write hit");
    endtask

    task automatic write_miss_allocate();
        start_test();
        write_word(make_addr(2, 1, 3), 32'h1234_abcd);
        check_value("allocate memory reads", read_count - reads_mark, 1);
        check_value("allocate memory writes", write_count - writes_mark, 0);
        read_word(make_addr(2, 1, 3));
        check_value("read after allocate stall", last_stall, 0);
        finish_test("write allocate");
    endtask

    task automatic lru_eviction();
        start_test();
        read_word(make_addr(3, 2, 0));
        read_word(make_addr(4, 2, 1));
        // touching A leaves B least recently used
        read_word(make_addr(3, 2, 2));
        read_word(make_addr(5, 2, 3));
        reads_mark = read_count;
        read_word(make_addr(3, 2, 3));
        check_value("A still resident", read_count - reads_mark, 0);
        read_word(make_addr(4, 2, 0));
        check_value("B was evicted", read_count - reads_mark, 1);
        check_value("memory writes", write_count - writes_mark, 0);
        finish_test("lru replacement");
    endtask

    task automatic dirty_eviction();
        start_test();
        write_word(make_addr(6, 3, 1), 32'h0bad_f00d);
        read_word(make_addr(7, 3, 0));
        read_word(make_addr(8, 3, 2));
        check_value("write-back count", write_count - writes_mark, 1);
        // the evicted word has to come back from memory
        read_word(make_addr(6, 3, 1));
        check_value("memory reads", read_count - reads_mark, 4);
        finish_test("dirty write-back");
    endtask

    task automatic random_stress();
        int    n;
        int    tag;
        int    idx;
        int    off;
        word_t data;
        start_test();
        for (n = 0; n < STRESS_ACCESSES; n++) begin
            tag  = 9 + int'($urandom_range(0, 2));
            idx  = int'($urandom_range(0, 3));
            off  = int'($urandom_range(0, 3));
            data = $urandom();
            if ($urandom_range(0, 1) == 1) begin
                write_word(make_addr(tag, idx, off), data);
            end else begin
                read_word(make_addr(tag, idx, off));
            end
        end
        finish_test("random stress");
    endtask

    initial begin
        int a;
        seed_draw   = $urandom(32'hd28f6911);
        proc_reset  = 1'b1;
        proc_read   = 1'b0;
        proc_write  = 1'b0;
        proc_addr   = '0;
        proc_wdata  = '0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        for (a = 0; a < SHADOW_WORDS; a++) begin
            shadow[a] = pattern_word(a);
        end
        apply_reset();
        read_miss_then_hit();
        write_hit_update();
        write_miss_allocate();
        lru_eviction();
        dirty_eviction();
        random_stress();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- files.f
rtl/cache_pkg.sv
rtl/way_array.sv
rtl/word_access.sv
rtl/set_lookup.sv
rtl/miss_control.sv
rtl/cache_top.sv
tests/tb_clock.sv
tests/mem_model.sv
tests/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cache_tb -f files.f -o cache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
